// File: filelist.f
+incdir+.
rp_pkg.sv
linear_calib.sv
adc_frontend.sv
dac_frontend.sv
analog_regs.sv
analog_top.sv
tb_analog_top.sv

// File: tb_analog_tasks.svh
`ifndef TB_ANALOG_TASKS_SVH
`define TB_ANALOG_TASKS_SVH

//////////////////////////////
// Random source
//////////////////////////////

// Galois LFSR, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// Signed value of n bits, one LFSR step per bit
function automatic int rand_signed(input int n);
  int v;
  v = 0;
  for (int i = 0; i < n; i++) begin
    v = (v << 1) | int'(lfsr_state[0]);
    lfsr_state = lfsr_next(lfsr_state);
  end
  return (v >= (1 << (n - 1))) ? v - (1 << n) : v;
endfunction

//////////////////////////////
// Reference model
//////////////////////////////

// Clamp to the signed sample range
function automatic int clip(input int x);
  if (x > SMP_MAX) return SMP_MAX;
  if (x < SMP_MIN) return SMP_MIN;
  return x;
endfunction

// Negative slope offset binary, code SMP_MAX is zero
function automatic int from_code(input int raw);
  return SMP_MAX - raw;
endfunction

function automatic int to_code(input int smp);
  return SMP_MAX - smp;
endfunction

// Gain in Q2.14, floor shift, then offset
function automatic int calib(input int x, input int mul, input int sum);
  return clip(((x * mul) >>> (MW - 2)) + sum);
endfunction

function automatic int src_sum(input int gen, input int fb, input bit ena);
  return clip(gen + (ena ? fb : 0));
endfunction

//////////////////////////////
// Bus access
//////////////////////////////

task automatic bus_write(input logic [BUS_AW-1:0] addr, input int data);
  @(posedge adc_clk);
  #DRV_DLY;
  sys_addr  = addr;
  sys_wdata = data;
  sys_wen   = 1'b1;
  @(posedge adc_clk);
  #DRV_DLY;
  sys_wen = 1'b0;
  assert (sys_ack) else begin
    err_cnt++;
    $display("Write to address 0x%02h got no acknowledge on the next cycle", addr);
  end
endtask

task automatic bus_read(input logic [BUS_AW-1:0] addr, output int data);
  @(posedge adc_clk);
  #DRV_DLY;
  sys_addr = addr;
  sys_ren  = 1'b1;
  @(posedge adc_clk);
  #DRV_DLY;
  sys_ren = 1'b0;
  data    = sys_rdata;
  assert (sys_ack) else begin
    err_cnt++;
    $display("Read from address 0x%02h got no acknowledge on the next cycle", addr);
  end
endtask

`endif

// File: tb_analog_top.sv
`default_nettype none
`timescale 1ns/100ps

module tb_analog_top;

  import rp_pkg::*;

  localparam int CHN        = CHN_NUM;
  localparam int DW         = SMP_DW;
  localparam int MW         = MUL_DW;
  localparam int SMP_MAX    = (1 << (DW - 1)) - 1;
  localparam int SMP_MIN    = -(1 << (DW - 1));
  localparam int CLK_PER    = 4;
  localparam int DRV_DLY    = 1;
  localparam int RST_CYC    = 16;
  localparam int STREAM_LEN = 64;
  // Streams and bus accesses over all tests plus margin
  localparam int N_STREAMS  = 9;
  localparam int BUS_OPS    = 20 * CHN;
  localparam int CYC_LIMIT  = RST_CYC + N_STREAMS * (STREAM_LEN + 5) + 2 * BUS_OPS + 200;

  logic                          adc_clk;
  logic                          top_rst;
  logic [BUS_AW-1:0]             sys_addr;
  logic [BUS_DW-1:0]             sys_wdata;
  logic                          sys_wen;
  logic                          sys_ren;
  logic [BUS_DW-1:0]             sys_rdata;
  logic                          sys_ack;
  logic        [CHN-1:0][DW-1:0] adc_raw;
  logic        [CHN-1:0][DW-1:0] dac_raw;
  logic signed [CHN-1:0][DW-1:0] gen_dat;
  logic signed [CHN-1:0][DW-1:0] fb_dat;
  logic signed [CHN-1:0][DW-1:0] adc_dat;

  logic [31:0] lfsr_state;
  int          err_cnt;
  int          err_mark;
  int          tests_run;
  int          tests_failed;
  int          cyc_cnt;
  bit          hit_hi;
  bit          hit_lo;
  // Model copy of the register file
  int          m_adc_mul [CHN];
  int          m_adc_sum [CHN];
  int          m_dac_mul [CHN];
  int          m_dac_sum [CHN];
  bit          m_loop;
  bit          m_fb;
  // Driven input history of one stream
  int          h_raw [STREAM_LEN+4][CHN];
  int          h_gen [STREAM_LEN+4][CHN];
  int          h_fb  [STREAM_LEN+4][CHN];

  `include "tb_analog_tasks.svh"

  analog_top #(.CHN (CHN), .DW (DW), .MW (MW)) uut (
    .top_rst     (top_rst),
    .adc_clk     (adc_clk),
    .sys_addr_i  (sys_addr),
    .sys_wdata_i (sys_wdata),
    .sys_wen_i   (sys_wen),
    .sys_ren_i   (sys_ren),
    .sys_rdata_o (sys_rdata),
    .sys_ack_o   (sys_ack),
    .adc_dat_i   (adc_raw),
    .dac_dat_o   (dac_raw),
    .gen_dat_i   (gen_dat),
    .fb_dat_i    (fb_dat),
    .adc_dat_o   (adc_dat)
  );

  initial begin
    adc_clk = 1'b0;
    forever #(CLK_PER / 2) adc_clk = ~adc_clk;
  end

  // Ack exactly one cycle after each strobe and at no other time
  assert property (@(posedge adc_clk) disable iff (top_rst)
                   sys_ack == $past(sys_wen | sys_ren))
  else begin
    err_cnt++;
    $display("Bus acknowledge at %0t ns did not follow a strobe by exactly one cycle", $time);
  end

  always @(posedge adc_clk) begin
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_cnt >= CYC_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYC_LIMIT);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  //////////////////////////////
  // Test helpers
  //////////////////////////////

  task automatic check_reg(input logic [BUS_AW-1:0] addr, input int exp);
    int rd;
    bus_read(addr, rd);
    assert (rd == exp) else begin
      err_cnt++;
      $display("Mismatch at %0t ns: register 0x%02h read 0x%08h, expected 0x%08h",
               $time, addr, rd, exp);
    end
  endtask

  // All four calibration words of one channel
  task automatic check_bank(input int ch);
    check_reg(ADC_MUL_ADDR + BUS_AW'(4 * ch), m_adc_mul[ch]);
    check_reg(ADC_SUM_ADDR + BUS_AW'(4 * ch), m_adc_sum[ch]);
    check_reg(DAC_MUL_ADDR + BUS_AW'(4 * ch), m_dac_mul[ch]);
    check_reg(DAC_SUM_ADDR + BUS_AW'(4 * ch), m_dac_sum[ch]);
  endtask

  task automatic set_cal(input logic [BUS_AW-1:0] base, input int ch, input int val);
    bus_write(base + BUS_AW'(4 * ch), val);
    case (base)
      ADC_MUL_ADDR: m_adc_mul[ch] = val;
      ADC_SUM_ADDR: m_adc_sum[ch] = val;
      DAC_MUL_ADDR: m_dac_mul[ch] = val;
      default:      m_dac_sum[ch] = val;
    endcase
  endtask

  task automatic set_cfg(input bit loop, input bit fb);
    bus_write(CFG_ADDR, {fb, loop});
    m_loop = loop;
    m_fb   = fb;
  endtask

  // One sample per cycle with outputs checked against the history
  task automatic run_stream(input int n, input bit extreme);
    int e_adc;
    int e_dac;
    for (int k = 0; k < n + 4; k++) begin
      @(posedge adc_clk);
      #DRV_DLY;
      for (int ch = 0; ch < CHN; ch++) begin
        if (k >= 4) begin
          e_dac = to_code(calib(src_sum(h_gen[k-3][ch], h_fb[k-3][ch], m_fb),
                                m_dac_mul[ch], m_dac_sum[ch]));
          // Loop path is one cycle longer than the raw path
          e_adc = m_loop ?
                  calib(calib(src_sum(h_gen[k-4][ch], h_fb[k-4][ch], m_fb),
                              m_dac_mul[ch], m_dac_sum[ch]), m_adc_mul[ch], m_adc_sum[ch]) :
                  calib(from_code(h_raw[k-3][ch]), m_adc_mul[ch], m_adc_sum[ch]);
          hit_hi |= (int'($signed(adc_dat[ch])) == SMP_MAX);
          hit_lo |= (int'($signed(adc_dat[ch])) == SMP_MIN);
          assert (int'(dac_raw[ch]) == e_dac) else begin
            err_cnt++;
            $display("Mismatch at %0t ns: dac_dat_o[%0d] = %0d, expected %0d",
                     $time, ch, dac_raw[ch], e_dac);
          end
          assert (int'($signed(adc_dat[ch])) == e_adc) else begin
            err_cnt++;
            $display("Mismatch at %0t ns: adc_dat_o[%0d] = %0d, expected %0d",
                     $time, ch, $signed(adc_dat[ch]), e_adc);
          end
        end
        h_raw[k][ch] = rand_signed(DW) & ((1 << DW) - 1);
        if (extreme) begin
          h_gen[k][ch] = (rand_signed(1) != 0) ? SMP_MIN : SMP_MAX;
          h_fb[k][ch]  = (rand_signed(1) != 0) ? SMP_MIN : SMP_MAX;
        end else begin
          h_gen[k][ch] = rand_signed(DW);
          h_fb[k][ch]  = rand_signed(DW);
        end
        adc_raw[ch] = DW'(h_raw[k][ch]);
        gen_dat[ch] = DW'(h_gen[k][ch]);
        fb_dat[ch]  = DW'(h_fb[k][ch]);
      end
    end
  endtask

  task automatic end_test(input int num, input string name);
    tests_run++;
    if (err_cnt != err_mark) tests_failed++;
    $display("Test %0d %s: %s", num, name, (err_cnt == err_mark) ? "passed" : "failed");
    err_mark = err_cnt;
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    top_rst      = 1'b1;
    sys_addr     = '0;
    sys_wdata    = '0;
    sys_wen      = 1'b0;
    sys_ren      = 1'b0;
    adc_raw      = '0;
    gen_dat      = '0;
    fb_dat       = '0;
    lfsr_state   = 32'h7676_4a8d;
    err_cnt      = 0;
    err_mark     = 0;
    tests_run    = 0;
    tests_failed = 0;
    cyc_cnt      = 0;
    m_loop       = 1'b0;
    m_fb         = 1'b0;
    for (int ch = 0; ch < CHN; ch++) begin
      m_adc_mul[ch] = int'(UNITY_GAIN);
      m_adc_sum[ch] = 0;
      m_dac_mul[ch] = int'(UNITY_GAIN);
      m_dac_sum[ch] = 0;
    end
    repeat (RST_CYC) @(posedge adc_clk);
    #DRV_DLY;
    top_rst = 1'b0;

    // Reset values and an unmapped address that reads zero
    check_reg(CFG_ADDR, 0);
    for (int ch = 0; ch < CHN; ch++) check_bank(ch);
    bus_write(8'h08, -1);
    check_reg(8'h08, 0);
    end_test(1, "register reset values and ack");

    run_stream(STREAM_LEN, 1'b0);
    end_test(2, "ADC default calibration");

    for (int ch = 0; ch < CHN; ch++) begin
      set_cal(ADC_MUL_ADDR, ch, rand_signed(MW));
      set_cal(ADC_SUM_ADDR, ch, rand_signed(DW));
    end
    run_stream(STREAM_LEN, 1'b0);
    // Offsets near alternate rails per channel
    for (int ch = 0; ch < CHN; ch++) begin
      set_cal(ADC_MUL_ADDR, ch, int'(UNITY_GAIN));
      set_cal(ADC_SUM_ADDR, ch, (ch % 2 == 0) ? SMP_MAX - 200 : SMP_MIN + 200);
    end
    hit_hi = 1'b0;
    hit_lo = 1'b0;
    run_stream(STREAM_LEN, 1'b0);
    assert (hit_hi && hit_lo) else begin
      err_cnt++;
      $display("ADC offsets near full scale did not drive the output to both rails");
    end
    end_test(3, "ADC gain, offset and saturation");

    for (int ch = 0; ch < CHN; ch++) begin
      set_cal(DAC_MUL_ADDR, ch, rand_signed(MW));
      set_cal(DAC_SUM_ADDR, ch, rand_signed(DW));
    end
    run_stream(STREAM_LEN, 1'b0);
    set_cfg(1'b0, 1'b1);
    run_stream(STREAM_LEN, 1'b0);
    run_stream(STREAM_LEN, 1'b1);
    end_test(4, "DAC sum, feedback gate and calibration");

    set_cfg(1'b1, 1'b1);
    run_stream(STREAM_LEN, 1'b0);
    end_test(5, "digital loop");

    // Channel 0 changes while the others keep their words
    set_cfg(1'b0, 1'b0);
    set_cal(ADC_MUL_ADDR, 0, rand_signed(MW));
    set_cal(DAC_SUM_ADDR, 0, rand_signed(DW));
    for (int ch = 1; ch < CHN; ch++) check_bank(ch);
    run_stream(STREAM_LEN, 1'b0);
    end_test(6, "channel isolation");

    $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule : tb_analog_top

`default_nettype wire

// File: analog_top.sv
`default_nettype none
`timescale 1ns/100ps

module analog_top #(
  parameter int CHN = rp_pkg::CHN_NUM,
  parameter int DW  = rp_pkg::SMP_DW,
  parameter int MW  = rp_pkg::MUL_DW
) (
  input  logic                          top_rst,
  input  logic                          adc_clk,
  // System bus
  input  logic [rp_pkg::BUS_AW-1:0]     sys_addr_i,
  input  logic [rp_pkg::BUS_DW-1:0]     sys_wdata_i,
  input  logic                          sys_wen_i,
  input  logic                          sys_ren_i,
  output logic [rp_pkg::BUS_DW-1:0]     sys_rdata_o,
  output logic                          sys_ack_o,
  // Raw converter codes
  input  logic        [CHN-1:0][DW-1:0] adc_dat_i,
  output logic        [CHN-1:0][DW-1:0] dac_dat_o,
  // Waveform and feedback samples
  input  logic signed [CHN-1:0][DW-1:0] gen_dat_i,
  input  logic signed [CHN-1:0][DW-1:0] fb_dat_i,
  // Calibrated ADC samples
  output logic signed [CHN-1:0][DW-1:0] adc_dat_o
);

  // Global switches
  logic                          digital_loop;
  logic                          fb_ena;
  // Per-channel calibration words
  logic signed [CHN-1:0][MW-1:0] adc_cfg_mul;
  logic signed [CHN-1:0][DW-1:0] adc_cfg_sum;
  logic signed [CHN-1:0][MW-1:0] dac_cfg_mul;
  logic signed [CHN-1:0][DW-1:0] dac_cfg_sum;
  // Calibrated DAC values, looped back to the ADC side
  logic signed [CHN-1:0][DW-1:0] dac_cal;

  //////////////////////////////
  // Register block
  //////////////////////////////

  analog_regs #(
    .CHN (CHN),
    .DW  (DW),
    .MW  (MW)
  ) u_regs (
    .adc_clk        (adc_clk),
    .top_rst        (top_rst),
    .sys_addr_i     (sys_addr_i),
    .sys_wdata_i    (sys_wdata_i),
    .sys_wen_i      (sys_wen_i),
    .sys_ren_i      (sys_ren_i),
    .sys_rdata_o    (sys_rdata_o),
    .sys_ack_o      (sys_ack_o),
    .digital_loop_o (digital_loop),
    .fb_ena_o       (fb_ena),
    .adc_mul_o      (adc_cfg_mul),
    .adc_sum_o      (adc_cfg_sum),
    .dac_mul_o      (dac_cfg_mul),
    .dac_sum_o      (dac_cfg_sum)
  );

  //////////////////////////////
  // ADC channels
  //////////////////////////////

  for (genvar i = 0; i < CHN; i++) begin : g_adc
    // Loop source is the matching DAC channel
    adc_frontend #(.DW (DW), .MW (MW)) u_adc (
      .adc_clk    (adc_clk),
      .top_rst    (top_rst),
      .raw_i      (adc_dat_i[i]),
      .loop_i     (digital_loop),
      .loop_dat_i (dac_cal[i]),
      .mul_i      (adc_cfg_mul[i]),
      .sum_i      (adc_cfg_sum[i]),
      .dat_o      (adc_dat_o[i])
    );
  end : g_adc

  //////////////////////////////
  // DAC channels
  //////////////////////////////

  for (genvar i = 0; i < CHN; i++) begin : g_dac
    dac_frontend #(.DW (DW), .MW (MW)) u_dac (
      .adc_clk  (adc_clk),
      .top_rst  (top_rst),
      .gen_i    (gen_dat_i[i]),
      .fb_i     (fb_dat_i[i]),
      .fb_ena_i (fb_ena),
      .mul_i    (dac_cfg_mul[i]),
      .sum_i    (dac_cfg_sum[i]),
      .cal_o    (dac_cal[i]),
      .dac_o    (dac_dat_o[i])
    );
  end : g_dac

endmodule : analog_top

`default_nettype wire

// File: analog_regs.sv
`default_nettype none
`timescale 1ns/100ps

module analog_regs #(
  parameter int CHN = rp_pkg::CHN_NUM,
  parameter int DW  = rp_pkg::SMP_DW,
  parameter int MW  = rp_pkg::MUL_DW
) (
  input  logic                          adc_clk,
  input  logic                          top_rst,
  // System bus
  input  logic [rp_pkg::BUS_AW-1:0]     sys_addr_i,
  input  logic [rp_pkg::BUS_DW-1:0]     sys_wdata_i,
  input  logic                          sys_wen_i,
  input  logic                          sys_ren_i,
  output logic [rp_pkg::BUS_DW-1:0]     sys_rdata_o,
  output logic                          sys_ack_o,
  // Global switches
  output logic                          digital_loop_o,
  output logic                          fb_ena_o,
  // Calibration banks
  output logic signed [CHN-1:0][MW-1:0] adc_mul_o,
  output logic signed [CHN-1:0][DW-1:0] adc_sum_o,
  output logic signed [CHN-1:0][MW-1:0] dac_mul_o,
  output logic signed [CHN-1:0][DW-1:0] dac_sum_o
);

  import rp_pkg::*;

  // Combinational read value for the current address
  logic [BUS_DW-1:0] rd_val;

  // Byte address of channel ch in a bank
  function automatic logic [BUS_AW-1:0] chn_addr(input logic [BUS_AW-1:0] base, input int ch);
    return base + BUS_AW'(4 * ch);
  endfunction

  //////////////////////////////
  // Write side
  //////////////////////////////

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      // Loop off, feedback off
      digital_loop_o <= 1'b0;
      fb_ena_o       <= 1'b0;
      // Unity gain, zero offset
      adc_mul_o      <= {CHN{MW'(UNITY_GAIN)}};
      adc_sum_o      <= '0;
      dac_mul_o      <= {CHN{MW'(UNITY_GAIN)}};
      dac_sum_o      <= '0;
    end else if (sys_wen_i) begin
      if (sys_addr_i == CFG_ADDR) begin
        digital_loop_o <= sys_wdata_i[CFG_LOOP_BIT];
        fb_ena_o       <= sys_wdata_i[CFG_FB_BIT];
      end
      // Unmatched addresses fall through untouched
      for (int ch = 0; ch < CHN; ch++) begin
        if (sys_addr_i == chn_addr(ADC_MUL_ADDR, ch)) adc_mul_o[ch] <= sys_wdata_i[MW-1:0];
        if (sys_addr_i == chn_addr(ADC_SUM_ADDR, ch)) adc_sum_o[ch] <= sys_wdata_i[DW-1:0];
        if (sys_addr_i == chn_addr(DAC_MUL_ADDR, ch)) dac_mul_o[ch] <= sys_wdata_i[MW-1:0];
        if (sys_addr_i == chn_addr(DAC_SUM_ADDR, ch)) dac_sum_o[ch] <= sys_wdata_i[DW-1:0];
      end
    end
  end

  //////////////////////////////
  // Read side
  //////////////////////////////

  // Address decode, zero for unmapped
  always_comb begin
    rd_val = '0;
    if (sys_addr_i == CFG_ADDR) begin
      rd_val[CFG_LOOP_BIT] = digital_loop_o;
      rd_val[CFG_FB_BIT]   = fb_ena_o;
    end
    // Signed fields sign-extended to bus width
    for (int ch = 0; ch < CHN; ch++) begin
      if (sys_addr_i == chn_addr(ADC_MUL_ADDR, ch))
        rd_val = {{(BUS_DW-MW){adc_mul_o[ch][MW-1]}}, adc_mul_o[ch]};
      if (sys_addr_i == chn_addr(ADC_SUM_ADDR, ch))
        rd_val = {{(BUS_DW-DW){adc_sum_o[ch][DW-1]}}, adc_sum_o[ch]};
      if (sys_addr_i == chn_addr(DAC_MUL_ADDR, ch))
        rd_val = {{(BUS_DW-MW){dac_mul_o[ch][MW-1]}}, dac_mul_o[ch]};
      if (sys_addr_i == chn_addr(DAC_SUM_ADDR, ch))
        rd_val = {{(BUS_DW-DW){dac_sum_o[ch][DW-1]}}, dac_sum_o[ch]};
    end
  end

  // Read data lands in the ack cycle
  always_ff @(posedge adc_clk) begin
    if (sys_ren_i) begin
      sys_rdata_o <= rd_val;
    end
  end

  // One-cycle ack after either strobe
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      sys_ack_o <= 1'b0;
    end else begin
      sys_ack_o <= sys_wen_i | sys_ren_i;
    end
  end

endmodule : analog_regs

`default_nettype wire

// File: dac_frontend.sv
`default_nettype none
`timescale 1ns/100ps

module dac_frontend #(
  parameter int DW = rp_pkg::SMP_DW,
  parameter int MW = rp_pkg::MUL_DW
) (
  input  logic                 adc_clk,
  input  logic                 top_rst,
  // Waveform and feedback sources
  input  logic signed [DW-1:0] gen_i,
  input  logic signed [DW-1:0] fb_i,
  input  logic                 fb_ena_i,
  // Calibration
  input  logic signed [MW-1:0] mul_i,
  input  logic signed [DW-1:0] sum_i,
  // Calibrated value for the digital loop
  output logic signed [DW-1:0] cal_o,
  // DAC code, offset binary with negative slope
  output logic        [DW-1:0] dac_o
);

  // Gated feedback sample
  logic signed [DW-1:0] fb_gate;
  // One guard bit for the sum
  logic signed [DW:0]   src_sum;
  logic signed [DW-1:0] src_sat;

  //////////////////////////////
  // Source sum
  //////////////////////////////

  assign fb_gate = fb_ena_i ? fb_i : {DW{1'b0}};
  assign src_sum = gen_i + fb_gate;

  // Top two bits disagree on overflow
  assign src_sat = (src_sum[DW] != src_sum[DW-1]) ?
                   {src_sum[DW], {(DW-1){~src_sum[DW]}}} :
                   src_sum[DW-1:0];

  //////////////////////////////
  // Calibration and output
  //////////////////////////////

  linear_calib #(.DW (DW), .MW (MW)) u_calib (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .dat_i   (src_sat),
    .mul_i   (mul_i),
    .sum_i   (sum_i),
    .dat_o   (cal_o)
  );

  // Output register, 0x1FFF is the zero code
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      dac_o <= {1'b0, {(DW-1){1'b1}}};
    end else begin
      dac_o <= {cal_o[DW-1], ~cal_o[DW-2:0]};
    end
  end

endmodule : dac_frontend

`default_nettype wire

// File: adc_frontend.sv
`default_nettype none
`timescale 1ns/100ps

module adc_frontend #(
  parameter int DW = rp_pkg::SMP_DW,
  parameter int MW = rp_pkg::MUL_DW
) (
  input  logic                 adc_clk,
  input  logic                 top_rst,
  // Raw ADC code, offset binary with negative slope
  input  logic        [DW-1:0] raw_i,
  // Digital loop select and source
  input  logic                 loop_i,
  input  logic signed [DW-1:0] loop_dat_i,
  // Calibration
  input  logic signed [MW-1:0] mul_i,
  input  logic signed [DW-1:0] sum_i,
  output logic signed [DW-1:0] dat_o
);

  // Input sample in two's complement
  logic signed [DW-1:0] adc_smp;
  // Sample entering calibration
  logic signed [DW-1:0] cal_in;

  // Input register, keep the top bit and invert the rest
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      adc_smp <= '0;
    end else begin
      adc_smp <= {raw_i[DW-1], ~raw_i[DW-2:0]};
    end
  end

  // Loop multiplexer, no register
  assign cal_in = loop_i ? loop_dat_i : adc_smp;

  // Gain and offset, two cycles
  linear_calib #(.DW (DW), .MW (MW)) u_calib (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .dat_i   (cal_in),
    .mul_i   (mul_i),
    .sum_i   (sum_i),
    .dat_o   (dat_o)
  );

endmodule : adc_frontend

`default_nettype wire

// File: linear_calib.sv
`default_nettype none
`timescale 1ns/100ps

module linear_calib #(
  parameter int DW = rp_pkg::SMP_DW,
  parameter int MW = rp_pkg::MUL_DW
) (
  input  logic                 adc_clk,
  input  logic                 top_rst,
  // Sample in
  input  logic signed [DW-1:0] dat_i,
  // Gain in Q2.(MW-2), offset in sample units
  input  logic signed [MW-1:0] mul_i,
  input  logic signed [DW-1:0] sum_i,
  // Calibrated sample out
  output logic signed [DW-1:0] dat_o
);

  // Product width after dropping MW-2 fraction bits
  localparam int PW = DW + 2;

  // Full product
  logic signed [DW+MW-1:0] mul_full;
  // Stage 1 register, shifted product
  logic signed [PW-1:0]    prd_reg;
  // Offset sum with one guard bit
  logic signed [PW:0]      sum_full;
  logic                    sum_ovf;

  //////////////////////////////
  // Stage 1, multiply and shift
  //////////////////////////////

  assign mul_full = dat_i * mul_i;

  // Dropping the low bits is a floor shift
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      prd_reg <= '0;
    end else begin
      prd_reg <= mul_full[DW+MW-1:MW-2];
    end
  end

  //////////////////////////////
  // Stage 2, offset and saturate
  //////////////////////////////

  assign sum_full = prd_reg + sum_i;

  // In range only when all bits above DW-2 match
  assign sum_ovf = ~(&sum_full[PW:DW-1]) & (|sum_full[PW:DW-1]);

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      dat_o <= '0;
    end else if (sum_ovf) begin
      // Clip to the rail on the side of the sign
      dat_o <= {sum_full[PW], {(DW-1){~sum_full[PW]}}};
    end else begin
      dat_o <= sum_full[DW-1:0];
    end
  end

endmodule : linear_calib

`default_nettype wire

// File: rp_pkg.sv
`default_nettype none

package rp_pkg;

  //////////////////////////////
  // Channel and datapath widths
  //////////////////////////////

  // Default number of analog channels
  localparam int CHN_NUM = 2;

  // Sample width of ADC and DAC codes
  localparam int SMP_DW = 14;

  // Gain word width, signed Q2.14
  localparam int MUL_DW = 16;

  // Gain of 1.0 in Q2.14
  localparam logic [MUL_DW-1:0] UNITY_GAIN = 16'd16384;

  //////////////////////////////
  // System bus
  //////////////////////////////

  localparam int BUS_AW = 8;
  localparam int BUS_DW = 32;

  // Config word and its bits
  localparam logic [BUS_AW-1:0] CFG_ADDR = 8'h00;
  localparam int CFG_LOOP_BIT = 0;
  localparam int CFG_FB_BIT   = 1;

  // Calibration banks, channel n at base + 4*n
  localparam logic [BUS_AW-1:0] ADC_MUL_ADDR = 8'h10;
  localparam logic [BUS_AW-1:0] ADC_SUM_ADDR = 8'h20;
  localparam logic [BUS_AW-1:0] DAC_MUL_ADDR = 8'h30;
  localparam logic [BUS_AW-1:0] DAC_SUM_ADDR = 8'h40;

endpackage : rp_pkg

`default_nettype wire
